// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f vlog.f --top-module tb_ctrl_top
	./obj_dir/Vtb_ctrl_top | tee /dev/stderr | grep -q "sim passed"

lint:
	verilator --lint-only --timing -f vlog.f --top-module tb_ctrl_top

clean:
	rm -rf obj_dir

// File: source/ctrl_pkg.sv
//--------------------------------------------------------------------------
// Control block shared definitions
// Register map, compatibility number and packet stage state encodings
//--------------------------------------------------------------------------
package ctrl_pkg;

   // Bus address widths
   localparam int SR_AWIDTH = 8;
   localparam int RB_AWIDTH = 8;

   // Settings bus register map
   typedef enum logic [SR_AWIDTH-1:0] {
      SR_LEDS       = 8'd0,
      SR_SW_RST     = 8'd1,
      SR_CLOCK_CTRL = 8'd2,
      SR_SFPP_CTRL0 = 8'd8,
      SR_SFPP_CTRL1 = 8'd9,
      SR_FIFOFLAGS  = 8'd10
   } sr_addr_e;

   // Readback bus map
   typedef enum logic [RB_AWIDTH-1:0] {
      RB_COUNTER      = 8'd0,
      RB_CLK_STATUS   = 8'd3,
      RB_COMPAT_NUM   = 8'd6,
      RB_SFPP_STATUS0 = 8'd8,
      RB_SFPP_STATUS1 = 8'd9,
      RB_FIFOFLAGS    = 8'd10
   } rb_addr_e;

   // Image compatibility, major in upper half
   localparam logic [15:0] COMPAT_MAJOR = 16'h0009;
   localparam logic [15:0] COMPAT_MINOR = 16'h0000;

   // Bit 6 high keeps the GPSDO on out of reset
   localparam logic [6:0] CLOCK_CTRL_RESET = 7'b100_0000;

   // Merge arbiter, idle or locked to one input until tlast
   typedef enum logic [1:0] {
      MERGE_IDLE,
      MERGE_PORT0,
      MERGE_PORT1
   } merge_state_e;

   // Split router, header beat or rest of packet
   typedef enum logic {
      SPLIT_HEADER,
      SPLIT_BODY
   } split_state_e;

endpackage

// File: source/ctrl_top.sv
//--------------------------------------------------------------------------
// Motherboard control and management block
// Settings registers, status readback and CPU packet merge/split
//--------------------------------------------------------------------------
module ctrl_top #(
   parameter int DATA_W = 64,
   parameter int USER_W = 4
) (
   input  logic              clk,
   input  logic              reset,
   // Settings bus, one write per strobe
   input  logic              i_set_stb,
   input  logic [7:0]        i_set_addr,
   input  logic [31:0]       i_set_data,
   // Readback bus
   input  logic [7:0]        i_rb_addr,
   input  logic              i_rb_rd_stb,
   output logic [31:0]       o_rb_data,
   // Board status pins
   input  logic [4:0]        i_clock_status,
   input  logic [2:0]        i_sfpp0_status,
   input  logic [2:0]        i_sfpp1_status,
   input  logic [3:0]        i_fifo_flags,
   // Configuration outputs
   output logic [7:0]        o_leds,
   output logic [3:0]        o_sw_rst,
   output logic [6:0]        o_clock_control,
   output logic [1:0]        o_sfpp0_rs,
   output logic [1:0]        o_sfpp1_rs,
   // Ethernet port 0 to CPU
   input  logic [DATA_W-1:0] i_e2z0_tdata,
   input  logic [USER_W-1:0] i_e2z0_tuser,
   input  logic              i_e2z0_tlast,
   input  logic              i_e2z0_tvalid,
   output logic              i_e2z0_tready,
   // Ethernet port 1 to CPU
   input  logic [DATA_W-1:0] i_e2z1_tdata,
   input  logic [USER_W-1:0] i_e2z1_tuser,
   input  logic              i_e2z1_tlast,
   input  logic              i_e2z1_tvalid,
   output logic              i_e2z1_tready,
   // Merged stream into the CPU
   output logic [DATA_W-1:0] o_zpui_tdata,
   output logic [USER_W-1:0] o_zpui_tuser,
   output logic              o_zpui_tlast,
   output logic              o_zpui_tvalid,
   input  logic              o_zpui_tready,
   // CPU outbound stream
   input  logic [DATA_W-1:0] i_zpuo_tdata,
   input  logic [USER_W-1:0] i_zpuo_tuser,
   input  logic              i_zpuo_tlast,
   input  logic              i_zpuo_tvalid,
   output logic              i_zpuo_tready,
   // CPU to Ethernet port 0
   output logic [DATA_W-1:0] o_z2e0_tdata,
   output logic [USER_W-1:0] o_z2e0_tuser,
   output logic              o_z2e0_tlast,
   output logic              o_z2e0_tvalid,
   input  logic              o_z2e0_tready,
   // CPU to Ethernet port 1
   output logic [DATA_W-1:0] o_z2e1_tdata,
   output logic [USER_W-1:0] o_z2e1_tuser,
   output logic              o_z2e1_tlast,
   output logic              o_z2e1_tvalid,
   input  logic              o_z2e1_tready
);

   logic       flags_clear;
   logic [1:0] sfp_clear;
   logic [5:0] sfp0_status;
   logic [5:0] sfp1_status;

   //-----------------------------------------------------------------------
   // Register path
   //-----------------------------------------------------------------------
   setting_regs setting_regs0 (
      .clk(clk), .reset(reset),
      .i_set_stb(i_set_stb),
      .i_set_addr(ctrl_pkg::sr_addr_e'(i_set_addr)),
      .i_set_data(i_set_data),
      .o_leds(o_leds), .o_sw_rst(o_sw_rst), .o_clock_control(o_clock_control),
      .o_sfpp0_rs(o_sfpp0_rs), .o_sfpp1_rs(o_sfpp1_rs),
      .o_flags_clear(flags_clear)
   );

   // One monitor per SFP+ cage
   sfp_status_monitor sfp_mon0 (
      .clk(clk), .reset(reset),
      .i_pins(i_sfpp0_status), .i_clear(sfp_clear[0]), .o_status(sfp0_status)
   );

   sfp_status_monitor sfp_mon1 (
      .clk(clk), .reset(reset),
      .i_pins(i_sfpp1_status), .i_clear(sfp_clear[1]), .o_status(sfp1_status)
   );

   readback_unit readback0 (
      .clk(clk), .reset(reset),
      .i_rb_addr(ctrl_pkg::rb_addr_e'(i_rb_addr)),
      .i_rb_rd_stb(i_rb_rd_stb),
      .i_clock_status(i_clock_status),
      .i_sfp0_status(sfp0_status), .i_sfp1_status(sfp1_status),
      .i_fifo_flags(i_fifo_flags), .i_flags_clear(flags_clear),
      .o_sfp_clear(sfp_clear), .o_rb_data(o_rb_data)
   );

   //-----------------------------------------------------------------------
   // Packet path
   //-----------------------------------------------------------------------
   stream_merge #(.DATA_W(DATA_W), .USER_W(USER_W)) zpui_merge (
      .clk(clk), .reset(reset),
      .i0_tdata(i_e2z0_tdata), .i0_tuser(i_e2z0_tuser), .i0_tlast(i_e2z0_tlast),
      .i0_tvalid(i_e2z0_tvalid), .i0_tready(i_e2z0_tready),
      .i1_tdata(i_e2z1_tdata), .i1_tuser(i_e2z1_tuser), .i1_tlast(i_e2z1_tlast),
      .i1_tvalid(i_e2z1_tvalid), .i1_tready(i_e2z1_tready),
      .o_tdata(o_zpui_tdata), .o_tuser(o_zpui_tuser), .o_tlast(o_zpui_tlast),
      .o_tvalid(o_zpui_tvalid), .o_tready(o_zpui_tready)
   );

   // Destination port from top byte of the first word
   stream_split #(.DATA_W(DATA_W), .USER_W(USER_W)) zpuo_split (
      .clk(clk), .reset(reset),
      .i_tdata(i_zpuo_tdata), .i_tuser(i_zpuo_tuser), .i_tlast(i_zpuo_tlast),
      .i_tvalid(i_zpuo_tvalid), .i_tready(i_zpuo_tready),
      .o0_tdata(o_z2e0_tdata), .o0_tuser(o_z2e0_tuser), .o0_tlast(o_z2e0_tlast),
      .o0_tvalid(o_z2e0_tvalid), .o0_tready(o_z2e0_tready),
      .o1_tdata(o_z2e1_tdata), .o1_tuser(o_z2e1_tuser), .o1_tlast(o_z2e1_tlast),
      .o1_tvalid(o_z2e1_tvalid), .o1_tready(o_z2e1_tready)
   );

endmodule

// File: source/readback_unit.sv
//--------------------------------------------------------------------------
// Readback mux with free-running counter and sticky FIFO fault flags
//--------------------------------------------------------------------------
module readback_unit (
   input  logic                clk,
   input  logic                reset,
   input  ctrl_pkg::rb_addr_e  i_rb_addr,
   input  logic                i_rb_rd_stb,
   input  logic [4:0]          i_clock_status,
   input  logic [5:0]          i_sfp0_status,
   input  logic [5:0]          i_sfp1_status,
   input  logic [3:0]          i_fifo_flags,
   input  logic                i_flags_clear,
   output logic [1:0]          o_sfp_clear,
   output logic [31:0]         o_rb_data
);

   logic [31:0] counter;
   logic [3:0]  fifo_flags;

   //-----------------------------------------------------------------------
   // Status state
   //-----------------------------------------------------------------------
   // Timestamp for software, one tick per clock
   always_ff @(posedge clk) begin
      if (reset) begin
         counter <= '0;
      end else begin
         counter <= counter + 32'd1;
      end
   end

   // FIFO flags are active low at the pins
   always_ff @(posedge clk) begin
      if (reset || i_flags_clear) begin
         fifo_flags <= '0;
      end else begin
         fifo_flags <= fifo_flags | ~i_fifo_flags;
      end
   end

   // Reading an SFP+ status word clears its change bits
   assign o_sfp_clear[0] = i_rb_rd_stb && (i_rb_addr == ctrl_pkg::RB_SFPP_STATUS0);
   assign o_sfp_clear[1] = i_rb_rd_stb && (i_rb_addr == ctrl_pkg::RB_SFPP_STATUS1);

   //-----------------------------------------------------------------------
   // Address mux
   //-----------------------------------------------------------------------
   always_comb begin
      case (i_rb_addr)
         ctrl_pkg::RB_COMPAT_NUM:   o_rb_data = {ctrl_pkg::COMPAT_MAJOR, ctrl_pkg::COMPAT_MINOR};
         ctrl_pkg::RB_COUNTER:      o_rb_data = counter;
         ctrl_pkg::RB_CLK_STATUS:   o_rb_data = {27'd0, i_clock_status};
         ctrl_pkg::RB_SFPP_STATUS0: o_rb_data = {26'd0, i_sfp0_status};
         ctrl_pkg::RB_SFPP_STATUS1: o_rb_data = {26'd0, i_sfp1_status};
         ctrl_pkg::RB_FIFOFLAGS:    o_rb_data = {28'd0, fifo_flags};
         // Unmapped
         default:                   o_rb_data = 32'd0;
      endcase
   end

   // At most one cage cleared per read
   sfp_clear_onehot: assert property (
      @(posedge clk) disable iff (reset) $onehot0(o_sfp_clear)
   );

endmodule

// File: source/setting_regs.sv
//--------------------------------------------------------------------------
// Settings bus decode into the board configuration registers
//--------------------------------------------------------------------------
module setting_regs (
   input  logic                clk,
   input  logic                reset,
   input  logic                i_set_stb,
   input  ctrl_pkg::sr_addr_e  i_set_addr,
   input  logic [31:0]         i_set_data,
   output logic [7:0]          o_leds,
   output logic [3:0]          o_sw_rst,
   output logic [6:0]          o_clock_control,
   output logic [1:0]          o_sfpp0_rs,
   output logic [1:0]          o_sfpp1_rs,
   output logic                o_flags_clear
);

   // SW_RST bits
   // [0] PHY reset, [1] radio clock domain reset, [2] radio PLL reset
   // SFP+ rate selects are pull-low enables, high pulls the pin to ground

   always_ff @(posedge clk) begin
      if (reset) begin
         o_leds          <= '0;
         o_sw_rst        <= '0;
         o_clock_control <= ctrl_pkg::CLOCK_CTRL_RESET;
         o_sfpp0_rs      <= '0;
         o_sfpp1_rs      <= '0;
         o_flags_clear   <= 1'b0;
      end else begin
         // Single cycle pulse unless another clear write follows
         o_flags_clear <= 1'b0;
         if (i_set_stb) begin
            case (i_set_addr)
               ctrl_pkg::SR_LEDS:       o_leds          <= i_set_data[7:0];
               ctrl_pkg::SR_SW_RST:     o_sw_rst        <= i_set_data[3:0];
               ctrl_pkg::SR_CLOCK_CTRL: o_clock_control <= i_set_data[6:0];
               ctrl_pkg::SR_SFPP_CTRL0: o_sfpp0_rs      <= i_set_data[1:0];
               ctrl_pkg::SR_SFPP_CTRL1: o_sfpp1_rs      <= i_set_data[1:0];
               // Data ignored, the write itself clears the flags
               ctrl_pkg::SR_FIFOFLAGS:  o_flags_clear   <= 1'b1;
               default: ;
            endcase
         end
      end
   end

   // Back to back clear cycles need back to back strobes
   flags_clear_pulse: assert property (
      @(posedge clk) disable iff (reset)
      o_flags_clear && $past(o_flags_clear) |-> $past(i_set_stb) && $past(i_set_stb, 2)
   );

endmodule

// File: source/sfp_status_monitor.sv
//--------------------------------------------------------------------------
// SFP+ status pin synchronizer with sticky change detect
//--------------------------------------------------------------------------
module sfp_status_monitor (
   input  logic       clk,
   input  logic       reset,
   input  logic [2:0] i_pins,
   input  logic       i_clear,
   output logic [5:0] o_status
);

   // Pin order ModAbs, TxFault, RxLOS
   logic [2:0] pins_meta;
   logic [2:0] pins_sync;
   logic [2:0] changed;

   // Two flop synchronizer
   always_ff @(posedge clk) begin
      pins_meta <= i_pins;
      pins_sync <= pins_meta;
   end

   // Sticky change bits
   // Clear wins over a change on the same edge
   always_ff @(posedge clk) begin
      if (reset || i_clear) begin
         changed <= '0;
      end else begin
         changed <= changed | (pins_meta ^ pins_sync);
      end
   end

   assign o_status = {changed, pins_sync};

endmodule

// File: source/stream_merge.sv
//--------------------------------------------------------------------------
// Two into one packet merge, round robin per packet, registered output
//--------------------------------------------------------------------------
module stream_merge #(
   parameter int DATA_W = 64,
   parameter int USER_W = 4
) (
   input  logic              clk,
   input  logic              reset,
   input  logic [DATA_W-1:0] i0_tdata,
   input  logic [USER_W-1:0] i0_tuser,
   input  logic              i0_tlast,
   input  logic              i0_tvalid,
   output logic              i0_tready,
   input  logic [DATA_W-1:0] i1_tdata,
   input  logic [USER_W-1:0] i1_tuser,
   input  logic              i1_tlast,
   input  logic              i1_tvalid,
   output logic              i1_tready,
   output logic [DATA_W-1:0] o_tdata,
   output logic [USER_W-1:0] o_tuser,
   output logic              o_tlast,
   output logic              o_tvalid,
   input  logic              o_tready
);

   ctrl_pkg::merge_state_e state;
   logic last_port;
   logic grant;
   logic grant_last;
   logic load;
   logic xfer;

   // Grant, locked mid packet
   always_comb begin
      case (state)
         ctrl_pkg::MERGE_PORT0: grant = 1'b0;
         ctrl_pkg::MERGE_PORT1: grant = 1'b1;
         // Packet start, the port not served last goes first if valid
         default:               grant = last_port ? !i0_tvalid : i1_tvalid;
      endcase
   end

   assign grant_last = grant ? i1_tlast : i0_tlast;
   // Output register empty or draining this cycle
   assign load = !o_tvalid || o_tready;
   assign xfer = load && (grant ? i1_tvalid : i0_tvalid);
   assign i0_tready = load && !grant;
   assign i1_tready = load && grant;

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= ctrl_pkg::MERGE_IDLE;
         last_port <= 1'b1;
         o_tvalid  <= 1'b0;
      end else if (xfer) begin
         o_tvalid  <= 1'b1;
         last_port <= grant;
         if (grant_last) begin
            state <= ctrl_pkg::MERGE_IDLE;
         end else begin
            state <= grant ? ctrl_pkg::MERGE_PORT1 : ctrl_pkg::MERGE_PORT0;
         end
      end else if (o_tready) begin
         o_tvalid <= 1'b0;
      end
   end

   // Output beat register
   always_ff @(posedge clk) begin
      if (xfer) begin
         o_tdata <= grant ? i1_tdata : i0_tdata;
         o_tuser <= grant ? i1_tuser : i0_tuser;
         o_tlast <= grant_last;
      end
   end

   // Stalled beat stays put
   out_hold: assert property (
      @(posedge clk) disable iff (reset)
      o_tvalid && !o_tready |=> o_tvalid && $stable(o_tdata)
   );

endmodule

// File: source/stream_split.sv
//--------------------------------------------------------------------------
// One into two packet router keyed on the header top byte
//--------------------------------------------------------------------------
module stream_split #(
   parameter int DATA_W = 64,
   parameter int USER_W = 4
) (
   input  logic              clk,
   input  logic              reset,
   input  logic [DATA_W-1:0] i_tdata,
   input  logic [USER_W-1:0] i_tuser,
   input  logic              i_tlast,
   input  logic              i_tvalid,
   output logic              i_tready,
   output logic [DATA_W-1:0] o0_tdata,
   output logic [USER_W-1:0] o0_tuser,
   output logic              o0_tlast,
   output logic              o0_tvalid,
   input  logic              o0_tready,
   output logic [DATA_W-1:0] o1_tdata,
   output logic [USER_W-1:0] o1_tuser,
   output logic              o1_tlast,
   output logic              o1_tvalid,
   input  logic              o1_tready
);

   ctrl_pkg::split_state_e state;
   logic dest_q;
   logic dest;
   logic xfer;

   // Port 0 only for a zero top byte, held until tlast
   assign dest = (state == ctrl_pkg::SPLIT_HEADER) ? (i_tdata[DATA_W-1 -: 8] != 8'd0) : dest_q;
   // Room when the occupied output drains
   assign i_tready = (!o0_tvalid || o0_tready) && (!o1_tvalid || o1_tready);
   assign xfer = i_tvalid && i_tready;

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= ctrl_pkg::SPLIT_HEADER;
         dest_q    <= 1'b0;
         o0_tvalid <= 1'b0;
         o1_tvalid <= 1'b0;
      end else if (xfer) begin
         o0_tvalid <= !dest;
         o1_tvalid <= dest;
         dest_q    <= dest;
         state     <= i_tlast ? ctrl_pkg::SPLIT_HEADER : ctrl_pkg::SPLIT_BODY;
      end else begin
         if (o0_tready) o0_tvalid <= 1'b0;
         if (o1_tready) o1_tvalid <= 1'b0;
      end
   end

   // Shared beat register, valids pick the port
   always_ff @(posedge clk) begin
      if (xfer) begin
         o0_tdata <= i_tdata;
         o0_tuser <= i_tuser;
         o0_tlast <= i_tlast;
      end
   end

   assign o1_tdata = o0_tdata;
   assign o1_tuser = o0_tuser;
   assign o1_tlast = o0_tlast;

   // A beat goes to one port only
   one_dest: assert property (
      @(posedge clk) disable iff (reset) !(o0_tvalid && o1_tvalid)
   );

endmodule

// File: verif/tb_tests.svh
//--------------------------------------------------------------------------
// Directed tests for the control block
//--------------------------------------------------------------------------

task automatic test_reset_values();
   logic [31:0] rd;
   check_word("o_clock_control", 32'(ctrl_pkg::CLOCK_CTRL_RESET), 32'(o_clock_control));
   // GPSDO enable is on out of reset
   check_bit("o_clock_control[6]", 1'b1, o_clock_control[6]);
   check_word("o_leds", 32'd0, 32'(o_leds));
   check_word("o_sw_rst", 32'd0, 32'(o_sw_rst));
   check_word("o_sfpp_rs", 32'd0, 32'({o_sfpp1_rs, o_sfpp0_rs}));
   read_rb(8'd6, 1'b0, rd);
   check_word("o_rb_data", {16'h0009, 16'h0000}, rd);
   // Unmapped address
   read_rb(8'd5, 1'b0, rd);
   check_word("o_rb_data", 32'd0, rd);
endtask

task automatic test_setting_writes();
   write_setting(8'd0, 32'h1234_56a5);
   check_word("o_leds", 32'ha5, 32'(o_leds));
   write_setting(8'd1, 32'hffff_fff6);
   check_word("o_sw_rst", 32'h6, 32'(o_sw_rst));
   write_setting(8'd2, 32'h0000_002b);
   check_word("o_clock_control", 32'h2b, 32'(o_clock_control));
   write_setting(8'd8, 32'h0000_0001);
   check_word("o_sfpp0_rs", 32'h1, 32'(o_sfpp0_rs));
   write_setting(8'd9, 32'h0000_0002);
   check_word("o_sfpp1_rs", 32'h2, 32'(o_sfpp1_rs));
   // Writes off the map leave every register alone
   write_setting(8'd5, 32'hffff_ffff);
   write_setting(8'hff, 32'hffff_ffff);
   check_word("o_leds", 32'ha5, 32'(o_leds));
   check_word("o_sw_rst", 32'h6, 32'(o_sw_rst));
   check_word("o_clock_control", 32'h2b, 32'(o_clock_control));
   check_word("o_sfpp_rs", 32'h9, 32'({o_sfpp1_rs, o_sfpp0_rs}));
endtask

task automatic test_status_reads();
   logic [31:0] c0, c1, rd;
   // Samples 7 falling edges apart
   read_rb(8'd0, 1'b0, c0);
   repeat (5) @(negedge clk);
   read_rb(8'd0, 1'b0, c1);
   check_word("counter delta", 32'd7, c1 - c0);
   i_clock_status = 5'h15;
   read_rb(8'd3, 1'b0, rd);
   check_word("o_rb_data", 32'h15, rd);
   // Flag pins are active low
   @(negedge clk);
   i_fifo_flags = 4'b1011;
   @(negedge clk);
   i_fifo_flags = 4'hf;
   read_rb(8'd10, 1'b0, rd);
   check_word("o_rb_data", 32'h4, rd);
   write_setting(8'd10, 32'd0);
   read_rb(8'd10, 1'b0, rd);
   check_word("o_rb_data", 32'h0, rd);
endtask

task automatic test_sfp_status();
   logic [31:0] rd;
   @(negedge clk);
   i_sfpp0_status = 3'b010;
   i_sfpp1_status = 3'b001;
   repeat (5) @(negedge clk);
   // Change bits above the synchronized pins
   read_rb(8'd8, 1'b1, rd);
   check_word("o_rb_data", 32'h12, rd);
   read_rb(8'd8, 1'b0, rd);
   check_word("o_rb_data", 32'h02, rd);
   // Port 1 change bit survives the port 0 clear
   read_rb(8'd9, 1'b0, rd);
   check_word("o_rb_data", 32'h09, rd);
   read_rb(8'd9, 1'b1, rd);
   check_word("o_rb_data", 32'h09, rd);
   read_rb(8'd9, 1'b0, rd);
   check_word("o_rb_data", 32'h01, rd);
endtask

task automatic test_merge();
   logic [DATA_W-1:0] d0[$], d1[$];
   logic l0[$], l1[$];
   int p0 = 0, p1 = 0, e0 = 0, e1 = 0, got = 0, port = 0, prev = -1;
   logic in_pkt = 1'b0;
   // Port 0 lengths 3 then 2, port 1 lengths 2 then 3
   for (int i = 0; i < 5; i++) begin
      d0.push_back(rand_data());
      l0.push_back(i == 2 || i == 4);
      d1.push_back(rand_data());
      l1.push_back(i == 1 || i == 4);
   end
   while (got < 10) begin
      @(negedge clk);
      i_e2z0_tvalid = (p0 < 5);
      i_e2z0_tdata = d0[p0 < 5 ? p0 : 4];
      i_e2z0_tlast = l0[p0 < 5 ? p0 : 4];
      i_e2z0_tuser = 4'h1;
      i_e2z1_tvalid = (p1 < 5);
      i_e2z1_tdata = d1[p1 < 5 ? p1 : 4];
      i_e2z1_tlast = l1[p1 < 5 ? p1 : 4];
      i_e2z1_tuser = 4'h2;
      o_zpui_tready = rand_bit();
      #1;
      if (i_e2z0_tvalid && i_e2z0_tready) p0++;
      if (i_e2z1_tvalid && i_e2z1_tready) p1++;
      if (o_zpui_tvalid && o_zpui_tready) begin
         if (!in_pkt) begin
            port = (e0 < 5 && o_zpui_tdata === d0[e0]) ? 0 : 1;
            if (port == prev) begin
               $display("ERROR: merge sent two packets in a row from port %0d", port);
               abort_run();
            end
         end
         if (port == 0) begin
            check_data("o_zpui_tdata", d0[e0], o_zpui_tdata);
            check_bit("o_zpui_tlast", l0[e0], o_zpui_tlast);
            e0++;
         end else begin
            check_data("o_zpui_tdata", d1[e1], o_zpui_tdata);
            check_bit("o_zpui_tlast", l1[e1], o_zpui_tlast);
            e1++;
         end
         check_word("o_zpui_tuser", 32'(port + 1), 32'(o_zpui_tuser));
         in_pkt = !o_zpui_tlast;
         if (o_zpui_tlast) prev = port;
         got++;
      end
   end
   @(negedge clk);
   {i_e2z0_tvalid, i_e2z1_tvalid, o_zpui_tready} = '0;
endtask

task automatic test_split();
   logic [DATA_W-1:0] src[$], q0[$], q1[$];
   logic [USER_W-1:0] src_user[$], qu0[$], qu1[$];
   logic src_last[$], ql0[$], ql1[$];
   int lens[4] = '{2, 3, 1, 2};
   int p = 0, got = 0;
   logic [DATA_W-1:0] d;
   logic [USER_W-1:0] u;
   logic to1;
   // Even packets carry a zero top byte, odd packets a non-zero one
   for (int k = 0; k < 4; k++) begin
      to1 = (k % 2 != 0);
      u = 4'(k + 5);
      for (int b = 0; b < lens[k]; b++) begin
         d = rand_data();
         if (b == 0) begin
            d[63:56] = to1 ? (d[63:56] | 8'h01) : 8'h00;
         end
         src.push_back(d);
         src_user.push_back(u);
         src_last.push_back(b == lens[k] - 1);
         if (to1) begin
            q1.push_back(d);
            qu1.push_back(u);
            ql1.push_back(b == lens[k] - 1);
         end else begin
            q0.push_back(d);
            qu0.push_back(u);
            ql0.push_back(b == lens[k] - 1);
         end
      end
   end
   while (got < src.size()) begin
      @(negedge clk);
      i_zpuo_tvalid = (p < src.size());
      i_zpuo_tdata = src[p < src.size() ? p : 0];
      i_zpuo_tuser = src_user[p < src.size() ? p : 0];
      i_zpuo_tlast = src_last[p < src.size() ? p : 0];
      o_z2e0_tready = rand_bit();
      o_z2e1_tready = rand_bit();
      #1;
      if (i_zpuo_tvalid && i_zpuo_tready) p++;
      if (o_z2e0_tvalid && o_z2e0_tready) begin
         if (q0.size() == 0) begin
            $display("ERROR: unexpected beat on o_z2e0");
            abort_run();
         end
         check_data("o_z2e0_tdata", q0.pop_front(), o_z2e0_tdata);
         check_word("o_z2e0_tuser", 32'(qu0.pop_front()), 32'(o_z2e0_tuser));
         check_bit("o_z2e0_tlast", ql0.pop_front(), o_z2e0_tlast);
         got++;
      end
      if (o_z2e1_tvalid && o_z2e1_tready) begin
         if (q1.size() == 0) begin
            $display("ERROR: unexpected beat on o_z2e1");
            abort_run();
         end
         check_data("o_z2e1_tdata", q1.pop_front(), o_z2e1_tdata);
         check_word("o_z2e1_tuser", 32'(qu1.pop_front()), 32'(o_z2e1_tuser));
         check_bit("o_z2e1_tlast", ql1.pop_front(), o_z2e1_tlast);
         got++;
      end
   end
   @(negedge clk);
   {i_zpuo_tvalid, o_z2e0_tready, o_z2e1_tready} = '0;
endtask

// File: verif/tb_ctrl_top.sv
//--------------------------------------------------------------------------
// Testbench for the control block registers, readback and packet stages
//--------------------------------------------------------------------------
module tb_ctrl_top;

   localparam int DATA_W = 64;
   localparam int USER_W = 4;
   localparam int MAX_CYCLES = 2000;

   logic clk;
   logic reset;
   logic i_set_stb, i_rb_rd_stb;
   logic [7:0] i_set_addr, i_rb_addr;
   logic [31:0] i_set_data, o_rb_data;
   logic [4:0] i_clock_status;
   logic [2:0] i_sfpp0_status, i_sfpp1_status;
   logic [3:0] i_fifo_flags, o_sw_rst;
   logic [7:0] o_leds;
   logic [6:0] o_clock_control;
   logic [1:0] o_sfpp0_rs, o_sfpp1_rs;
   logic [DATA_W-1:0] i_e2z0_tdata, i_e2z1_tdata, o_zpui_tdata;
   logic [DATA_W-1:0] i_zpuo_tdata, o_z2e0_tdata, o_z2e1_tdata;
   logic [USER_W-1:0] i_e2z0_tuser, i_e2z1_tuser, o_zpui_tuser;
   logic [USER_W-1:0] i_zpuo_tuser, o_z2e0_tuser, o_z2e1_tuser;
   logic i_e2z0_tlast, i_e2z0_tvalid, i_e2z0_tready;
   logic i_e2z1_tlast, i_e2z1_tvalid, i_e2z1_tready;
   logic o_zpui_tlast, o_zpui_tvalid, o_zpui_tready;
   logic i_zpuo_tlast, i_zpuo_tvalid, i_zpuo_tready;
   logic o_z2e0_tlast, o_z2e0_tvalid, o_z2e0_tready;
   logic o_z2e1_tlast, o_z2e1_tvalid, o_z2e1_tready;

   logic [31:0] lfsr = 32'h3231e453;
   int fail_count = 0;
   int cycles = 0;

   ctrl_top #(.DATA_W(DATA_W), .USER_W(USER_W)) dut0 (.*);

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // Run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("ERROR: timeout after %0d cycles, a test never finished", cycles);
         abort_run();
      end
   end

   //-----------------------------------------------------------------------
   // Helpers
   //-----------------------------------------------------------------------
   // Fibonacci LFSR on taps 32 22 2 1
   // Stepped once per bit
   function automatic logic rand_bit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [DATA_W-1:0] rand_data();
      logic [DATA_W-1:0] d;
      for (int i = 0; i < DATA_W; i++) begin
         d[i] = rand_bit();
      end
      return d;
   endfunction

   task automatic abort_run();
      fail_count++;
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   // Single strobe write
   // Register holds the new value once this returns
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(negedge clk);
      i_set_stb = 1'b1;
      i_set_addr = addr;
      i_set_data = data;
      @(negedge clk);
      i_set_stb = 1'b0;
   endtask

   // Combinational readback sampled just after the falling edge
   task automatic read_rb(input logic [7:0] addr, input logic stb, output logic [31:0] data);
      @(negedge clk);
      i_rb_addr = addr;
      i_rb_rd_stb = stb;
      #1;
      data = o_rb_data;
      @(negedge clk);
      i_rb_rd_stb = 1'b0;
   endtask

   `include "tb_tests.svh"

   //-----------------------------------------------------------------------
   // Test sequence
   //-----------------------------------------------------------------------
   initial begin
      reset = 1'b1;
      {i_set_stb, i_rb_rd_stb, i_set_addr, i_rb_addr, i_set_data} = '0;
      i_clock_status = '0;
      i_sfpp0_status = '0;
      i_sfpp1_status = '0;
      i_fifo_flags = 4'hf;
      {i_e2z0_tdata, i_e2z0_tuser, i_e2z0_tlast, i_e2z0_tvalid} = '0;
      {i_e2z1_tdata, i_e2z1_tuser, i_e2z1_tlast, i_e2z1_tvalid} = '0;
      {i_zpuo_tdata, i_zpuo_tuser, i_zpuo_tlast, i_zpuo_tvalid} = '0;
      {o_zpui_tready, o_z2e0_tready, o_z2e1_tready} = '0;
      repeat (8) @(negedge clk);
      reset = 1'b0;
      test_reset_values();
      test_setting_writes();
      test_status_reads();
      test_sfp_status();
      test_merge();
      test_split();
      if (fail_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: vlog.f
+incdir+verif
source/ctrl_pkg.sv
source/setting_regs.sv
source/sfp_status_monitor.sv
source/readback_unit.sv
source/stream_merge.sv
source/stream_split.sv
source/ctrl_top.sv
verif/tb_ctrl_top.sv
